// File: list.f
m6502_pkg.sv
m6502_alu.sv
m6502_regs.sv
m6502_seq.sv
m6502_exec_top.sv
tb_m6502_exec_asserts.sv
tb_m6502_exec.sv

// File: m6502_alu.sv
`timescale 1ns/1ps
`default_nettype none

module m6502_alu import m6502_pkg::*; (
   input  wire       clk,
   input  wire       reset_n,
   input  wire       proceed,
   input  wire       alu_op_t op,
   input  wire       byte_t in_a,
   input  wire       byte_t in_b,
   input  wire       flag_c_set,
   input  wire       flag_c_reset,
   input  wire       flag_d_set,
   input  wire       flag_d_reset,
   input  wire       flag_v_reset,
   output byte_t     out,
   output logic      flag_c,
   output logic      flag_z,
   output logic      flag_v,
   output logic      flag_n,
   output logic      flag_d
);

   logic [8:0] result;
   logic [8:0] sum;
   logic [8:0] diff;
   logic       next_c;
   logic       next_v;
   logic       proceed_prev;
   logic       start;
   logic       out_new;      // out changed on the last edge
   alu_op_t    op_post;
   alu_op_t    post_code;

   logic       c_set_prev;
   logic       c_reset_prev;
   logic       d_set_prev;
   logic       d_reset_prev;
   logic       v_reset_prev;
   logic       c_set_rise;
   logic       c_reset_rise;
   logic       d_set_rise;
   logic       d_reset_rise;
   logic       v_reset_rise;

   assign out   = result[7:0];
   assign start = proceed & ~proceed_prev;
   assign sum   = {1'b0, in_a} + {1'b0, in_b} + {8'd0, flag_c};
   assign diff  = {1'b0, in_a} - {1'b0, in_b};   // Bit 8 is the borrow

   assign c_set_rise   = flag_c_set   & ~c_set_prev;
   assign c_reset_rise = flag_c_reset & ~c_reset_prev;
   assign d_set_rise   = flag_d_set   & ~d_set_prev;
   assign d_reset_rise = flag_d_reset & ~d_reset_prev;
   assign v_reset_rise = flag_v_reset & ~v_reset_prev;

   always_comb begin
      case (op)
         OP_ADC:                         post_code = OP_ADC;
         OP_CMP:                         post_code = OP_CMP;
         OP_ASL, OP_LSR, OP_ROL, OP_ROR: post_code = OP_UPDATE_C;
         default:                        post_code = OP_NOP;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Operation stage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         proceed_prev <= 1'b0;
         op_post      <= OP_NOP;
         out_new      <= 1'b0;
      end else begin
         proceed_prev <= proceed;
         out_new      <= start;
         op_post      <= start ? post_code : OP_NOP;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         case (op)
            OP_UPDATE: result <= {1'b0, in_a};
            OP_AND:    result <= {1'b0, in_a & in_b};
            OP_OR:     result <= {1'b0, in_a | in_b};
            OP_EOR:    result <= {1'b0, in_a ^ in_b};
            OP_ADC: begin
               result <= sum;
               next_v <= (in_a[7] == in_b[7]) && (sum[7] != in_a[7]);   // Signed overflow
            end
            OP_INC:    result <= {1'b0, in_a + 8'd1};
            OP_DEC:    result <= {1'b0, in_a - 8'd1};
            OP_CMP:    result <= diff;
            OP_ASL: begin
               result <= {in_a, 1'b0};
               next_c <= in_a[7];
            end
            OP_LSR: begin
               result <= {2'b00, in_a[7:1]};
               next_c <= in_a[0];
            end
            OP_ROL: begin
               result <= {1'b0, in_a[6:0], flag_c};
               next_c <= in_a[7];
            end
            OP_ROR: begin
               result <= {1'b0, flag_c, in_a[7:1]};
               next_c <= in_a[0];
            end
            default: result <= result;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Flag register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         c_set_prev   <= 1'b0;
         c_reset_prev <= 1'b0;
         d_set_prev   <= 1'b0;
         d_reset_prev <= 1'b0;
         v_reset_prev <= 1'b0;
         flag_c       <= 1'b0;
         flag_z       <= 1'b0;
         flag_v       <= 1'b0;
         flag_n       <= 1'b0;
         flag_d       <= 1'b0;
      end else begin
         c_set_prev   <= flag_c_set;
         c_reset_prev <= flag_c_reset;
         d_set_prev   <= flag_d_set;
         d_reset_prev <= flag_d_reset;
         v_reset_prev <= flag_v_reset;

         if (out_new) begin
            flag_z <= (out == 8'h00);
            flag_n <= out[7];
         end

         if (c_set_rise) begin
            flag_c <= 1'b1;
         end else if (c_reset_rise) begin
            flag_c <= 1'b0;
         end else if (d_set_rise) begin
            flag_d <= 1'b1;
         end else if (d_reset_rise) begin
            flag_d <= 1'b0;
         end else if (v_reset_rise) begin
            flag_v <= 1'b0;
         end else begin
            case (op_post)
               OP_ADC: begin
                  flag_c <= result[8];
                  flag_v <= next_v;
               end
               OP_CMP:      flag_c <= ~result[8];   // Not borrow
               OP_UPDATE_C: flag_c <= next_c;
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: m6502_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module m6502_exec_top import m6502_pkg::*; (
   input  wire       clk,
   input  wire       reset_n,
   input  wire       cmd_valid,
   output logic      cmd_ready,
   input  wire       alu_op_t cmd_op,
   input  wire       flag_act_t cmd_flag,
   input  wire       reg_sel_t cmd_dst,
   input  wire       reg_sel_t cmd_src,
   input  wire       cmd_use_imm,
   input  wire       byte_t cmd_imm,
   output logic      res_valid,
   input  wire       res_ready,
   output byte_t     res_data,
   output logic      flag_c,
   output logic      flag_z,
   output logic      flag_v,
   output logic      flag_n,
   output logic      flag_d
);

   reg_sel_t rd_a_sel;
   reg_sel_t rd_b_sel;
   reg_sel_t wr_sel;
   byte_t    rd_a;
   byte_t    rd_b;
   logic     wr_en;
   logic     proceed;
   alu_op_t  alu_op;
   byte_t    alu_in_a;
   byte_t    alu_in_b;
   byte_t    alu_out;
   logic     flag_c_set;
   logic     flag_c_reset;
   logic     flag_d_set;
   logic     flag_d_reset;
   logic     flag_v_reset;

   m6502_seq u_seq (
      .clk          (clk),
      .reset_n      (reset_n),
      .cmd_valid    (cmd_valid),
      .cmd_op       (cmd_op),
      .cmd_flag     (cmd_flag),
      .cmd_dst      (cmd_dst),
      .cmd_src      (cmd_src),
      .cmd_use_imm  (cmd_use_imm),
      .cmd_imm      (cmd_imm),
      .res_ready    (res_ready),
      .rd_a         (rd_a),
      .rd_b         (rd_b),
      .alu_out      (alu_out),
      .cmd_ready    (cmd_ready),
      .res_valid    (res_valid),
      .res_data     (res_data),
      .rd_a_sel     (rd_a_sel),
      .rd_b_sel     (rd_b_sel),
      .wr_sel       (wr_sel),
      .wr_en        (wr_en),
      .proceed      (proceed),
      .alu_op       (alu_op),
      .alu_in_a     (alu_in_a),
      .alu_in_b     (alu_in_b),
      .flag_c_set   (flag_c_set),
      .flag_c_reset (flag_c_reset),
      .flag_d_set   (flag_d_set),
      .flag_d_reset (flag_d_reset),
      .flag_v_reset (flag_v_reset)
   );

   m6502_regs u_regs (
      .clk      (clk),
      .reset_n  (reset_n),
      .rd_a_sel (rd_a_sel),
      .rd_b_sel (rd_b_sel),
      .wr_en    (wr_en),
      .wr_sel   (wr_sel),
      .wr_data  (alu_out),    // Write-back always comes from the ALU
      .rd_a     (rd_a),
      .rd_b     (rd_b)
   );

   m6502_alu u_alu (
      .clk          (clk),
      .reset_n      (reset_n),
      .proceed      (proceed),
      .op           (alu_op),
      .in_a         (alu_in_a),
      .in_b         (alu_in_b),
      .flag_c_set   (flag_c_set),
      .flag_c_reset (flag_c_reset),
      .flag_d_set   (flag_d_set),
      .flag_d_reset (flag_d_reset),
      .flag_v_reset (flag_v_reset),
      .out          (alu_out),
      .flag_c       (flag_c),
      .flag_z       (flag_z),
      .flag_v       (flag_v),
      .flag_n       (flag_n),
      .flag_d       (flag_d)
   );

endmodule

`default_nettype wire

// File: m6502_pkg.sv
`default_nettype none

package m6502_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Data
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [7:0] byte_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Operation codes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef enum logic [3:0] {
      OP_UPDATE   = 4'd0,    // Copy in_a
      OP_AND      = 4'd1,
      OP_OR       = 4'd2,
      OP_EOR      = 4'd3,
      OP_ADC      = 4'd4,    // Add with carry
      OP_INC      = 4'd5,
      OP_DEC      = 4'd6,
      OP_CMP      = 4'd7,    // Subtract, result not written back
      OP_ASL      = 4'd8,
      OP_LSR      = 4'd9,
      OP_ROL      = 4'd10,
      OP_ROR      = 4'd11,
      OP_NOP      = 4'd12,   // Post stage only
      OP_UPDATE_C = 4'd13    // Post stage only
   } alu_op_t;

   typedef enum logic [2:0] {
      FLAG_NONE = 3'd0,      // Command is an ALU operation
      FLAG_SEC  = 3'd1,
      FLAG_CLC  = 3'd2,
      FLAG_SED  = 3'd3,
      FLAG_CLD  = 3'd4,
      FLAG_CLV  = 3'd5
   } flag_act_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Register select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef enum logic [1:0] {
      REG_A = 2'd0,
      REG_X = 2'd1,
      REG_Y = 2'd2
   } reg_sel_t;

endpackage

`default_nettype wire

// File: m6502_regs.sv
`timescale 1ns/1ps
`default_nettype none

module m6502_regs import m6502_pkg::*; (
   input  wire      clk,
   input  wire      reset_n,
   input  wire      reg_sel_t rd_a_sel,
   input  wire      reg_sel_t rd_b_sel,
   input  wire      wr_en,
   input  wire      reg_sel_t wr_sel,
   input  wire      byte_t wr_data,
   output byte_t    rd_a,
   output byte_t    rd_b
);

   byte_t reg_a;
   byte_t reg_x;
   byte_t reg_y;

   function automatic byte_t read_reg(input reg_sel_t sel, input byte_t a,
                                      input byte_t x, input byte_t y);
      byte_t value;
      case (sel)
         REG_A:   value = a;
         REG_X:   value = x;
         REG_Y:   value = y;
         default: value = 8'h00;   // Unused select code
      endcase
      return value;
   endfunction

   assign rd_a = read_reg(rd_a_sel, reg_a, reg_x, reg_y);
   assign rd_b = read_reg(rd_b_sel, reg_a, reg_x, reg_y);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         reg_a <= 8'h00;
         reg_x <= 8'h00;
         reg_y <= 8'h00;
      end else if (wr_en) begin
         case (wr_sel)
            REG_A:   reg_a <= wr_data;
            REG_X:   reg_x <= wr_data;
            REG_Y:   reg_y <= wr_data;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: m6502_seq.sv
`timescale 1ns/1ps
`default_nettype none

module m6502_seq import m6502_pkg::*; (
   input  wire       clk,
   input  wire       reset_n,
   input  wire       cmd_valid,
   input  wire       alu_op_t cmd_op,
   input  wire       flag_act_t cmd_flag,
   input  wire       reg_sel_t cmd_dst,
   input  wire       reg_sel_t cmd_src,
   input  wire       cmd_use_imm,
   input  wire       byte_t cmd_imm,
   input  wire       res_ready,
   input  wire       byte_t rd_a,
   input  wire       byte_t rd_b,
   input  wire       byte_t alu_out,
   output logic      cmd_ready,
   output logic      res_valid,
   output byte_t     res_data,
   output reg_sel_t  rd_a_sel,
   output reg_sel_t  rd_b_sel,
   output reg_sel_t  wr_sel,
   output logic      wr_en,
   output logic      proceed,
   output alu_op_t   alu_op,
   output byte_t     alu_in_a,
   output byte_t     alu_in_b,
   output logic      flag_c_set,
   output logic      flag_c_reset,
   output logic      flag_d_set,
   output logic      flag_d_reset,
   output logic      flag_v_reset
);

   typedef enum logic [2:0] {
      IDLE,
      ISSUE,     // Operands read, proceed or flag line high
      WAIT,      // ALU result valid
      WRITE,     // Flags settled, write-back
      PRESENT    // Result offered
   } state_t;

   state_t    state;
   logic      accept;
   logic      is_flag;
   alu_op_t   op_q;
   flag_act_t flag_q;
   reg_sel_t  dst_q;
   reg_sel_t  src_q;
   logic      use_imm_q;
   byte_t     imm_q;

   assign cmd_ready = (state == IDLE);
   assign accept    = cmd_valid & cmd_ready;
   assign is_flag   = (flag_q != FLAG_NONE);

   // Flag commands read A so the result port returns it unchanged
   assign rd_a_sel = is_flag ? REG_A : dst_q;
   assign rd_b_sel = src_q;
   assign alu_op   = op_q;
   assign alu_in_a = rd_a;
   assign alu_in_b = use_imm_q ? imm_q : rd_b;

   assign wr_sel = dst_q;
   assign wr_en  = (state == WRITE) && !is_flag && (op_q != OP_CMP);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Command FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state        <= IDLE;
         res_valid    <= 1'b0;
         proceed      <= 1'b0;
         flag_c_set   <= 1'b0;
         flag_c_reset <= 1'b0;
         flag_d_set   <= 1'b0;
         flag_d_reset <= 1'b0;
         flag_v_reset <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (accept) begin
                  state <= ISSUE;
                  case (cmd_flag)
                     FLAG_NONE: proceed      <= 1'b1;
                     FLAG_SEC:  flag_c_set   <= 1'b1;
                     FLAG_CLC:  flag_c_reset <= 1'b1;
                     FLAG_SED:  flag_d_set   <= 1'b1;
                     FLAG_CLD:  flag_d_reset <= 1'b1;
                     FLAG_CLV:  flag_v_reset <= 1'b1;
                     default: ;
                  endcase
               end
            end
            ISSUE: begin
               state <= WAIT;
            end
            WAIT: begin
               state        <= WRITE;   // Levels drop after two cycles high
               proceed      <= 1'b0;
               flag_c_set   <= 1'b0;
               flag_c_reset <= 1'b0;
               flag_d_set   <= 1'b0;
               flag_d_reset <= 1'b0;
               flag_v_reset <= 1'b0;
            end
            WRITE: begin
               state     <= PRESENT;
               res_valid <= 1'b1;
            end
            PRESENT: begin
               if (res_ready) begin
                  state     <= IDLE;
                  res_valid <= 1'b0;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Command latch and result hold
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (accept) begin
         op_q      <= cmd_op;
         flag_q    <= cmd_flag;
         dst_q     <= cmd_dst;
         src_q     <= cmd_src;
         use_imm_q <= cmd_use_imm;
         imm_q     <= cmd_imm;
      end
      if (state == WRITE) begin
         res_data <= is_flag ? rd_a : alu_out;   // Held until taken
      end
   end

endmodule

`default_nettype wire

// File: tb_m6502_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_m6502_exec import m6502_pkg::*; ();

   logic      clk;
   logic      reset_n;
   logic      cmd_valid;
   logic      cmd_ready;
   alu_op_t   cmd_op;
   flag_act_t cmd_flag;
   reg_sel_t  cmd_dst;
   reg_sel_t  cmd_src;
   logic      cmd_use_imm;
   byte_t     cmd_imm;
   logic      res_valid;
   logic      res_ready;
   byte_t     res_data;
   logic      flag_c, flag_z, flag_v, flag_n, flag_d;

   byte_t       model_reg [0:3];                    // A, X, Y by select code
   logic        m_c, m_z, m_v, m_n, m_d;
   integer      seed;
   logic [31:0] rnd;
   int          value_errors;
   int          timeouts;
   int          i;

   m6502_exec_top dut (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
      assert (got === exp) else begin
         $display("[FAIL] %0t %s expected %02h got %02h", $time, name, exp, got);
         value_errors++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model of registers and flags
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic predict(input alu_op_t op, input flag_act_t fl, input reg_sel_t dst,
                          input reg_sel_t src, input logic use_imm, input byte_t imm,
                          output byte_t r);
      byte_t      a;
      byte_t      b;
      logic [8:0] wide;
      a = (fl != FLAG_NONE) ? model_reg[REG_A] : model_reg[dst];
      b = use_imm ? imm : model_reg[src];
      r = a;
      case (fl)
         FLAG_SEC: m_c = 1'b1;
         FLAG_CLC: m_c = 1'b0;
         FLAG_SED: m_d = 1'b1;
         FLAG_CLD: m_d = 1'b0;
         FLAG_CLV: m_v = 1'b0;
         default: begin
            case (op)
               OP_AND: r = a & b;
               OP_OR:  r = a | b;
               OP_EOR: r = a ^ b;
               OP_ADC: begin
                  wide = {1'b0, a} + {1'b0, b} + {8'd0, m_c};
                  r    = wide[7:0];
                  m_v  = (a[7] == b[7]) && (r[7] != a[7]);   // Same signs in, other sign out
                  m_c  = wide[8];
               end
               OP_INC: r = a + 8'd1;
               OP_DEC: r = a - 8'd1;
               OP_CMP: begin
                  r   = a - b;
                  m_c = (a >= b);
               end
               OP_ASL: begin
                  r   = {a[6:0], 1'b0};
                  m_c = a[7];
               end
               OP_LSR: begin
                  r   = {1'b0, a[7:1]};
                  m_c = a[0];
               end
               OP_ROL: begin
                  r   = {a[6:0], m_c};   // Old carry in
                  m_c = a[7];
               end
               OP_ROR: begin
                  r   = {m_c, a[7:1]};
                  m_c = a[0];
               end
               default: r = a;            // Update copies the destination
            endcase
            m_z = (r == 8'h00);
            m_n = r[7];
            if (op != OP_CMP) model_reg[dst] = r;
         end
      endcase
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Command and result handshakes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic send_command(input alu_op_t op, input flag_act_t fl, input reg_sel_t dst,
                               input reg_sel_t src, input logic use_imm, input byte_t imm);
      int n;
      n = 0;
      @(posedge clk);
      cmd_valid   <= 1'b1;
      cmd_op      <= op;
      cmd_flag    <= fl;
      cmd_dst     <= dst;
      cmd_src     <= src;
      cmd_use_imm <= use_imm;
      cmd_imm     <= imm;
      @(negedge clk);
      while (!cmd_ready && n < 50) begin
         @(negedge clk);
         n++;
      end
      if (!cmd_ready) begin
         $display("Timeout at %0t: the DUT never raised cmd_ready", $time);
         timeouts++;
      end
      @(posedge clk);                                // Transfer edge
      cmd_valid <= 1'b0;
   endtask

   task automatic hold_result();
      @(posedge clk);
      res_ready <= 1'b0;
      cmd_valid <= 1'b1;                             // Second command must wait
      repeat (12) @(posedge clk);
      cmd_valid <= 1'b0;
   endtask

   task automatic take_result(input byte_t exp_data);
      int n;
      n = 0;
      while (n < 40) begin
         @(posedge clk);
         rnd = $random(seed);
         res_ready <= rnd[0];
         @(negedge clk);
         if (res_valid && res_ready) break;
         n++;
      end
      if (n == 40) begin
         $display("Timeout at %0t: no result was taken from the DUT", $time);
         timeouts++;
      end else begin
         check_value("res_data", exp_data, res_data);
         check_value("flag_c", {7'd0, m_c}, {7'd0, flag_c});
         check_value("flag_z", {7'd0, m_z}, {7'd0, flag_z});
         check_value("flag_v", {7'd0, m_v}, {7'd0, flag_v});
         check_value("flag_n", {7'd0, m_n}, {7'd0, flag_n});
         check_value("flag_d", {7'd0, m_d}, {7'd0, flag_d});
      end
      @(posedge clk);
      res_ready <= 1'b0;
   endtask

   task automatic run_command(input alu_op_t op, input flag_act_t fl, input reg_sel_t dst,
                              input reg_sel_t src, input logic use_imm, input byte_t imm,
                              input logic stall);
      byte_t exp_data;
      predict(op, fl, dst, src, use_imm, imm, exp_data);
      send_command(op, fl, dst, src, use_imm, imm);
      if (stall) hold_result();
      take_result(exp_data);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      seed         = 32'hf0b3_c27a;
      value_errors = 0;
      timeouts     = 0;
      reset_n      = 1'b0;
      cmd_valid    = 1'b0;
      cmd_op       = OP_UPDATE;
      cmd_flag     = FLAG_NONE;
      cmd_dst      = REG_A;
      cmd_src      = REG_A;
      cmd_use_imm  = 1'b0;
      cmd_imm      = 8'h00;
      res_ready    = 1'b0;
      model_reg    = '{default: 8'h00};
      {m_c, m_z, m_v, m_n, m_d} = 5'b00000;
      repeat (16) @(posedge clk);
      reset_n <= 1'b1;

      run_command(OP_UPDATE, FLAG_SEC, REG_A, REG_A, 1'b0, 8'h00, 1'b0);
      run_command(OP_UPDATE, FLAG_SED, REG_A, REG_A, 1'b0, 8'h00, 1'b0);
      run_command(OP_UPDATE, FLAG_CLD, REG_A, REG_A, 1'b0, 8'h00, 1'b0);
      run_command(OP_UPDATE, FLAG_CLC, REG_A, REG_A, 1'b0, 8'h00, 1'b0);
      run_command(OP_OR, FLAG_NONE, REG_A, REG_A, 1'b1, 8'h7f, 1'b0);
      run_command(OP_ADC, FLAG_NONE, REG_A, REG_A, 1'b1, 8'h01, 1'b0);   // Signed overflow
      run_command(OP_ADC, FLAG_NONE, REG_A, REG_A, 1'b1, 8'h80, 1'b1);   // Carry out
      run_command(OP_ADC, FLAG_NONE, REG_X, REG_A, 1'b0, 8'h00, 1'b0);   // Carry passed on
      run_command(OP_UPDATE, FLAG_CLV, REG_A, REG_A, 1'b0, 8'h00, 1'b0);
      run_command(OP_CMP, FLAG_NONE, REG_X, REG_A, 1'b1, 8'h01, 1'b0);
      run_command(OP_DEC, FLAG_NONE, REG_X, REG_A, 1'b0, 8'h00, 1'b0);   // X kept by cmp
      run_command(OP_DEC, FLAG_NONE, REG_X, REG_A, 1'b0, 8'h00, 1'b0);   // Wraps to ff
      run_command(OP_INC, FLAG_NONE, REG_X, REG_A, 1'b0, 8'h00, 1'b0);   // Wraps to 00

      for (i = 0; i < 300 && timeouts == 0; i++) begin
         rnd = $random(seed);
         run_command(alu_op_t'(rnd[3:0] % 4'd12),
                     (rnd[10:8] == 3'd0) ? flag_act_t'(3'd1 + rnd[13:11] % 3'd5) : FLAG_NONE,
                     reg_sel_t'(rnd[17:16] % 2'd3), reg_sel_t'(rnd[21:20] % 2'd3),
                     rnd[22], rnd[31:24], (i % 16) == 5);
      end

      $display("Value errors: %0d, assertion errors: %0d, timeouts: %0d",
               value_errors, dut.u_asserts.fail_count, timeouts);
      if (value_errors == 0 && timeouts == 0 && dut.u_asserts.fail_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_m6502_exec_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tb_m6502_exec_asserts (
   input wire       clk,
   input wire       reset_n,
   input wire       cmd_valid,
   input wire       cmd_ready,
   input wire       res_valid,
   input wire       res_ready,
   input wire [7:0] res_data,
   input wire       flag_c, flag_z, flag_v, flag_n, flag_d,
   input wire       proceed,
   input wire       wr_en,
   input wire       flag_c_set, flag_c_reset, flag_d_set, flag_d_reset, flag_v_reset
);

   int fail_count;

   initial fail_count = 0;

   // Accept cycle plus three more before the result shows
   latency_check: assert property (@(posedge clk) disable iff (!reset_n)
      (cmd_valid && cmd_ready) |=> (!res_valid) [*3] ##1 res_valid)
      else begin
         $error("Result latency differs from 4 cycles");
         fail_count++;
      end

   hold_check: assert property (@(posedge clk) disable iff (!reset_n)
      (res_valid && !res_ready) |=> res_valid && $stable(res_data)
         && $stable({flag_c, flag_z, flag_v, flag_n, flag_d}))
      else begin
         $error("Result changed under back-pressure");
         fail_count++;
      end

   busy_check: assert property (@(posedge clk) disable iff (!reset_n)
      res_valid |-> !cmd_ready)
      else begin
         $error("cmd_ready high while a result is pending");
         fail_count++;
      end

   reset_check: assert property (@(posedge clk)
      $rose(reset_n) |-> cmd_ready && !res_valid && !proceed && !wr_en
         && !(flag_c_set || flag_c_reset || flag_d_set || flag_d_reset || flag_v_reset)
         && !(flag_c || flag_z || flag_v || flag_n || flag_d))
      else begin
         $error("Wrong state after reset");
         fail_count++;
      end

endmodule

bind m6502_exec_top tb_m6502_exec_asserts u_asserts (.*);

`default_nettype wire
